/* element_wise_checker.sv */
module element_wise_checker (
    input logic         clk,
    input logic         rst,
    input logic         init_i,
    input logic         valid_in_i,
    input logic         valid_out_i,
    input logic [12:0]  elem_idx_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // input valids delayed by the lane latency
    logic [ew_pkg::LANE_LATENCY-1:0] vin_hist;

    always_ff @(posedge clk) begin
        if (!rst) begin
            vin_hist <= '0;
        end else begin
            vin_hist <= {vin_hist[ew_pkg::LANE_LATENCY-2:0], valid_in_i};
        end
    end

    // --------------------------------------------------
    // protocol properties
    // --------------------------------------------------
    a_latency: assert property (@(posedge clk) disable iff (!rst)
        valid_out_i == vin_hist[ew_pkg::LANE_LATENCY-1])
        else $error("valid_o does not follow valid_i by the pipeline latency");

    a_reset_quiet: assert property (@(posedge clk) !rst |=> !valid_out_i)
        else $error("valid_o high during reset");

    a_init_clear: assert property (@(posedge clk) disable iff (!rst)
        init_i |=> elem_idx_i == '0)
        else $error("elem_idx_o not cleared after init");

endmodule

bind element_wise_top element_wise_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .init_i      (init_i),
    .valid_in_i  (valid_i),
    .valid_out_i (valid_o),
    .elem_idx_i  (elem_idx_o)
);

/* element_wise_top.sv */
module element_wise_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                init_i,
    input  logic                valid_i,
    input  logic [1:0]          op_i,
    input  logic [3:0]          groups_i,
    input  logic [63:0]         data_a_i,
    input  logic [63:0]         data_b_i,
    // shared rescale parameters, held while vectors are in flight
    input  logic signed [31:0]  in1_offset_i,
    input  logic signed [31:0]  in2_offset_i,
    input  logic signed [31:0]  left_shift_i,
    input  logic        [31:0]  in1_mult_i,
    input  logic signed [31:0]  in1_shift_i,
    input  logic        [31:0]  in2_mult_i,
    input  logic signed [31:0]  in2_shift_i,
    input  logic        [31:0]  out_mult_i,
    input  logic signed [31:0]  out_shift_i,
    input  logic signed [31:0]  out_offset_i,
    input  logic signed [31:0]  act_min_i,
    input  logic signed [31:0]  act_max_i,
    output logic                valid_o,
    output logic [63:0]         data_o,
    output logic [12:0]         elem_idx_o
);

    // --------------------------------------------------
    // vector datapath
    // --------------------------------------------------
    ew_vector u_vector (
        .clk          (clk),
        .rst          (rst),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .groups_i     (groups_i),
        .data_a_i     (data_a_i),
        .data_b_i     (data_b_i),
        .in1_offset_i (in1_offset_i),
        .in2_offset_i (in2_offset_i),
        .left_shift_i (left_shift_i),
        .in1_mult_i   (in1_mult_i),
        .in1_shift_i  (in1_shift_i),
        .in2_mult_i   (in2_mult_i),
        .in2_shift_i  (in2_shift_i),
        .out_mult_i   (out_mult_i),
        .out_shift_i  (out_shift_i),
        .out_offset_i (out_offset_i),
        .act_min_i    (act_min_i),
        .act_max_i    (act_max_i),
        .valid_o      (valid_o),
        .data_o       (data_o)
    );

    // --------------------------------------------------
    // output element index for downstream addressing
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            elem_idx_o <= '0;
        end else if (init_i) begin
            // init beats a coincident output
            elem_idx_o <= '0;
        end else if (valid_o) begin
            elem_idx_o <= elem_idx_o + 13'd1;
        end
    end

endmodule

/* ew_lane.sv */
module ew_lane (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [ew_pkg::OP_W-1:0]             op_i,
    input  logic signed [ew_pkg::INT8_W-1:0]    a_i,
    input  logic signed [ew_pkg::INT8_W-1:0]    b_i,
    // stage flags from the vector valid pipeline
    input  logic                                rescale_in_valid_i,
    input  logic                                rescale_out_valid_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   in1_offset_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   in2_offset_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   left_shift_i,
    input  logic        [ew_pkg::INT32_W-1:0]   in1_mult_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   in1_shift_i,
    input  logic        [ew_pkg::INT32_W-1:0]   in2_mult_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   in2_shift_i,
    input  logic        [ew_pkg::INT32_W-1:0]   out_mult_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   out_shift_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   out_offset_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   act_min_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   act_max_i,
    output logic [ew_pkg::INT8_W-1:0]           y_o
);

    logic signed [ew_pkg::INT32_W-1:0]  s1_a;
    logic signed [ew_pkg::INT32_W-1:0]  s1_b;
    logic [ew_pkg::OP_W-1:0]            s1_op;
    logic signed [ew_pkg::INT32_W-1:0]  x1;
    logic signed [ew_pkg::INT32_W-1:0]  x2;
    logic signed [ew_pkg::INT32_W-1:0]  mul_c;

    logic signed [ew_pkg::INT32_W-1:0]  mul_dly [ew_pkg::QM_LATENCY];
    logic [ew_pkg::OP_W-1:0]            op_dly  [ew_pkg::QM_LATENCY];

    logic                               q1_valid;
    logic                               q2_valid;
    logic signed [ew_pkg::INT32_W-1:0]  q1_y;
    logic signed [ew_pkg::INT32_W-1:0]  q2_y;
    logic signed [ew_pkg::INT32_W-1:0]  sum_c;
    logic signed [ew_pkg::INT32_W-1:0]  comb_c;
    logic signed [ew_pkg::INT32_W-1:0]  comb_q;

    logic                               qo_valid;
    logic signed [ew_pkg::INT32_W-1:0]  qo_y;
    logic signed [ew_pkg::INT32_W-1:0]  off_c;
    logic signed [ew_pkg::INT32_W-1:0]  clamp_c;
    logic signed [ew_pkg::INT32_W-1:0]  sat_c;
    logic [ew_pkg::INT8_W-1:0]          y_q;

    // --------------------------------------------------
    // input register with offsets
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        s1_a  <= a_i + in1_offset_i;
        s1_b  <= b_i + in2_offset_i;
        s1_op <= op_i;
    end

    assign x1    = s1_a <<< left_shift_i;
    assign x2    = s1_b <<< left_shift_i;
    assign mul_c = s1_a * s1_b;

    quant_mul u_qm_in1 (
        .clk     (clk),
        .rst     (rst),
        .valid_i (rescale_in_valid_i),
        .x_i     (x1),
        .mult_i  (in1_mult_i),
        .shift_i (in1_shift_i),
        .valid_o (q1_valid),
        .y_o     (q1_y)
    );

    quant_mul u_qm_in2 (
        .clk     (clk),
        .rst     (rst),
        .valid_i (rescale_in_valid_i),
        .x_i     (x2),
        .mult_i  (in2_mult_i),
        .shift_i (in2_shift_i),
        .valid_o (q2_valid),
        .y_o     (q2_y)
    );

    // product and op code wait alongside the input rescale
    always_ff @(posedge clk) begin
        mul_dly[0] <= mul_c;
        op_dly[0]  <= s1_op;
        for (int k = 1; k < ew_pkg::QM_LATENCY; k++) begin
            mul_dly[k] <= mul_dly[k-1];
            op_dly[k]  <= op_dly[k-1];
        end
    end

    // --------------------------------------------------
    // combine register
    // --------------------------------------------------
    assign sum_c = q1_y + q2_y;

    always_comb begin
        case (op_dly[ew_pkg::QM_LATENCY-1])
            ew_pkg::OP_ADD: comb_c = sum_c;
            ew_pkg::OP_SUB: comb_c = q1_y - q2_y;
            ew_pkg::OP_MUL: comb_c = mul_dly[ew_pkg::QM_LATENCY-1];
            default:        comb_c = sum_c;
        endcase
    end

    always_ff @(posedge clk) begin
        if (q1_valid && q2_valid) begin
            comb_q <= comb_c;
        end
    end

    quant_mul u_qm_out (
        .clk     (clk),
        .rst     (rst),
        .valid_i (rescale_out_valid_i),
        .x_i     (comb_q),
        .mult_i  (out_mult_i),
        .shift_i (out_shift_i),
        .valid_o (qo_valid),
        .y_o     (qo_y)
    );

    // --------------------------------------------------
    // output offset, activation clamp, int8 saturation
    // --------------------------------------------------
    assign off_c = qo_y + out_offset_i;

    always_comb begin
        clamp_c = (off_c < act_min_i) ? act_min_i : off_c;
        if (clamp_c > act_max_i) begin
            clamp_c = act_max_i;
        end
        sat_c = clamp_c;
        if (sat_c > ew_pkg::INT8_MAX) begin
            sat_c = ew_pkg::INT8_MAX;
        end else if (sat_c < ew_pkg::INT8_MIN) begin
            sat_c = ew_pkg::INT8_MIN;
        end
    end

    always_ff @(posedge clk) begin
        if (qo_valid) begin
            y_q <= sat_c[ew_pkg::INT8_W-1:0];
        end
    end

    assign y_o = y_q;

endmodule

/* ew_pkg.sv */
package ew_pkg;

    // --------------------------------------------------
    // data widths
    // --------------------------------------------------
    localparam int INT8_W  = 8;
    localparam int INT32_W = 32;

    // lanes per vector and packed vector width
    localparam int LANES = 8;
    localparam int VEC_W = LANES * INT8_W;

    // group count and output element index
    localparam int GROUP_W = 4;
    localparam int IDX_W   = 13;

    // --------------------------------------------------
    // operation codes
    // --------------------------------------------------
    localparam int OP_W = 2;

    localparam logic [OP_W-1:0] OP_ADD = 2'd0;
    localparam logic [OP_W-1:0] OP_SUB = 2'd1;
    localparam logic [OP_W-1:0] OP_MUL = 2'd2;
    // code 3 falls back to add

    // --------------------------------------------------
    // pipeline latencies
    // --------------------------------------------------
    // valid_i to valid_o of one rescale unit
    localparam int QM_LATENCY = 2;

    // offset reg, input rescale, combine reg, output rescale, clamp reg
    localparam int LANE_LATENCY = 1 + QM_LATENCY + 1 + QM_LATENCY + 1;

    // --------------------------------------------------
    // final int8 saturation
    // --------------------------------------------------
    localparam int INT8_MIN = -128;
    localparam int INT8_MAX = 127;

endpackage

/* ew_vector.sv */
module ew_vector (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                valid_i,
    input  logic [ew_pkg::OP_W-1:0]             op_i,
    input  logic [ew_pkg::GROUP_W-1:0]          groups_i,
    input  logic [ew_pkg::VEC_W-1:0]            data_a_i,
    input  logic [ew_pkg::VEC_W-1:0]            data_b_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   in1_offset_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   in2_offset_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   left_shift_i,
    input  logic        [ew_pkg::INT32_W-1:0]   in1_mult_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   in1_shift_i,
    input  logic        [ew_pkg::INT32_W-1:0]   in2_mult_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   in2_shift_i,
    input  logic        [ew_pkg::INT32_W-1:0]   out_mult_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   out_shift_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   out_offset_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   act_min_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   act_max_i,
    output logic                                valid_o,
    output logic [ew_pkg::VEC_W-1:0]            data_o
);

    logic [ew_pkg::LANE_LATENCY-1:0]    vld_dly;
    logic [ew_pkg::GROUP_W-1:0]         grp_dly [ew_pkg::LANE_LATENCY];
    logic [ew_pkg::GROUP_W-1:0]         grp_last;

    // --------------------------------------------------
    // valid and group count pipeline
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            vld_dly <= '0;
            for (int k = 0; k < ew_pkg::LANE_LATENCY; k++) begin
                grp_dly[k] <= '0;
            end
        end else begin
            vld_dly    <= {vld_dly[ew_pkg::LANE_LATENCY-2:0], valid_i};
            // idle slots carry zero groups so data_o stays zero
            grp_dly[0] <= valid_i ? groups_i : '0;
            for (int k = 1; k < ew_pkg::LANE_LATENCY; k++) begin
                grp_dly[k] <= grp_dly[k-1];
            end
        end
    end

    assign grp_last = grp_dly[ew_pkg::LANE_LATENCY-1];
    assign valid_o  = vld_dly[ew_pkg::LANE_LATENCY-1];

    // --------------------------------------------------
    // lanes
    // --------------------------------------------------
    for (genvar i = 0; i < ew_pkg::LANES; i++) begin : g_lane
        logic [ew_pkg::INT8_W-1:0] lane_y;

        ew_lane u_lane (
            .clk                 (clk),
            .rst                 (rst),
            .op_i                (op_i),
            .a_i                 (data_a_i[i*ew_pkg::INT8_W +: ew_pkg::INT8_W]),
            .b_i                 (data_b_i[i*ew_pkg::INT8_W +: ew_pkg::INT8_W]),
            .rescale_in_valid_i  (vld_dly[0]),
            .rescale_out_valid_i (vld_dly[1 + ew_pkg::QM_LATENCY]),
            .in1_offset_i        (in1_offset_i),
            .in2_offset_i        (in2_offset_i),
            .left_shift_i        (left_shift_i),
            .in1_mult_i          (in1_mult_i),
            .in1_shift_i         (in1_shift_i),
            .in2_mult_i          (in2_mult_i),
            .in2_shift_i         (in2_shift_i),
            .out_mult_i          (out_mult_i),
            .out_shift_i         (out_shift_i),
            .out_offset_i        (out_offset_i),
            .act_min_i           (act_min_i),
            .act_max_i           (act_max_i),
            .y_o                 (lane_y)
        );

        // lanes at or above the group count read as zero
        assign data_o[i*ew_pkg::INT8_W +: ew_pkg::INT8_W] =
            (int'(grp_last) > i) ? lane_y : '0;
    end

endmodule

/* filelist.f */
ew_pkg.sv
quant_mul.sv
ew_lane.sv
ew_vector.sv
element_wise_top.sv
element_wise_checker.sv
tb_element_wise.sv

/* quant_mul.sv */
module quant_mul (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                valid_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   x_i,
    input  logic        [ew_pkg::INT32_W-1:0]   mult_i,
    input  logic signed [ew_pkg::INT32_W-1:0]   shift_i,
    output logic                                valid_o,
    output logic signed [ew_pkg::INT32_W-1:0]   y_o
);

    logic signed [ew_pkg::INT32_W-1:0]      x_shl;
    logic signed [2*ew_pkg::INT32_W-1:0]    x_ext;
    logic signed [2*ew_pkg::INT32_W-1:0]    m_ext;
    logic                                   ovf_c;
    logic [4:0]                             rsh_c;

    logic                                   s1_valid;
    logic signed [2*ew_pkg::INT32_W-1:0]    s1_prod;
    logic                                   s1_ovf;
    logic [4:0]                             s1_rsh;

    logic signed [2*ew_pkg::INT32_W-1:0]    nudge;
    logic signed [2*ew_pkg::INT32_W-1:0]    nudged;
    logic signed [ew_pkg::INT32_W-1:0]      high;
    logic        [ew_pkg::INT32_W-1:0]      mask;
    logic        [ew_pkg::INT32_W-1:0]      remainder;
    logic        [ew_pkg::INT32_W-1:0]      threshold;
    logic signed [ew_pkg::INT32_W-1:0]      rounded;

    // --------------------------------------------------
    // stage 1: left shift and full product
    // --------------------------------------------------
    assign x_shl = (shift_i > 0) ? (x_i <<< shift_i) : x_i;
    assign x_ext = x_shl;
    assign m_ext = $signed(mult_i);

    // only min * min overflows the doubling high mul
    assign ovf_c = (x_shl == 32'sh8000_0000) && (mult_i == 32'h8000_0000);

    // right shift amount, capped at word width
    always_comb begin
        if (shift_i >= 0) begin
            rsh_c = 5'd0;
        end else if (shift_i < -31) begin
            rsh_c = 5'd31;
        end else begin
            rsh_c = 5'(-shift_i);
        end
    end

    always_ff @(posedge clk) begin
        s1_prod <= x_ext * m_ext;
        s1_ovf  <= ovf_c;
        s1_rsh  <= rsh_c;
    end

    // --------------------------------------------------
    // stage 2: rounded high half, then rounding right shift
    // --------------------------------------------------
    assign nudge  = s1_prod[63] ? 64'shFFFF_FFFF_C000_0001 : 64'sh0000_0000_4000_0000;
    assign nudged = s1_prod + nudge;
    assign high   = s1_ovf ? 32'sh7FFF_FFFF : nudged[62:31];

    // round half away from zero
    assign mask      = (32'd1 << s1_rsh) - 32'd1;
    assign remainder = high & mask;
    assign threshold = (mask >> 1) + {31'd0, high[31]};
    assign rounded   = (high >>> s1_rsh) + ((remainder > threshold) ? 32'sd1 : 32'sd0);

    always_ff @(posedge clk) begin
        y_o <= rounded;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            s1_valid <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            s1_valid <= valid_i;
            valid_o  <= s1_valid;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the element-wise unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_element_wise -o sim_element_wise
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_element_wise)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

/* tb_element_wise.sv */
module tb_element_wise;

    timeunit 1ns;
    timeprecision 1ps;

    // about 110 busy cycles across all tests, with a wide margin
    localparam int TIMEOUT_CYCLES = 400;

    logic clk, rst, init_i, valid_i;
    logic [1:0] op_i;
    logic [3:0] groups_i;
    logic [ew_pkg::VEC_W-1:0] data_a_i, data_b_i;
    logic signed [31:0] in1_offset_i, in2_offset_i, left_shift_i, in1_shift_i, in2_shift_i;
    logic signed [31:0] out_shift_i, out_offset_i, act_min_i, act_max_i;
    logic [31:0] in1_mult_i, in2_mult_i, out_mult_i;
    logic valid_o;
    logic [ew_pkg::VEC_W-1:0] data_o;
    logic [12:0] elem_idx_o;

    int errors = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int exp_idx = 0;
    int cycle_cnt = 0;
    logic [1:0] op_q[$];
    logic [3:0] grp_q[$];
    logic [ew_pkg::VEC_W-1:0] a_q[$], b_q[$], exp_q[$];

    element_wise_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic int rescale(int x_in, int mult, int shift);
        int x;
        int high;
        longint prod;
        longint nudged;
        longint mag;
        longint q;
        x = x_in;
        if (shift > 0) x = x <<< shift;
        if (x == int'(32'h8000_0000) && mult == int'(32'h8000_0000)) begin
            high = int'(32'h7fff_ffff);
        end else begin
            prod = longint'(x) * longint'(mult);
            nudged = (prod >= 0) ? prod + 64'sd1073741824 : prod + 64'sd1 - 64'sd1073741824;
            high = int'(nudged >>> 31);
        end
        // divide by 2^-shift, halves away from zero
        if (shift < 0) begin
            mag = (high < 0) ? -longint'(high) : longint'(high);
            q = mag >> (-shift);
            if (2 * (mag - (q << (-shift))) >= (64'sd1 << (-shift))) q = q + 1;
            high = (high < 0) ? int'(-q) : int'(q);
        end
        return high;
    endfunction

    function automatic logic [7:0] lane_model(logic [1:0] op, logic signed [7:0] a,
                                              logic signed [7:0] b);
        int a1;
        int b1;
        int r;
        a1 = int'(a) + in1_offset_i;
        b1 = int'(b) + in2_offset_i;
        if (op == ew_pkg::OP_MUL) begin
            r = a1 * b1;
        end else if (op == ew_pkg::OP_SUB) begin
            r = rescale(a1 <<< left_shift_i, int'(in1_mult_i), in1_shift_i)
                - rescale(b1 <<< left_shift_i, int'(in2_mult_i), in2_shift_i);
        end else begin
            r = rescale(a1 <<< left_shift_i, int'(in1_mult_i), in1_shift_i)
                + rescale(b1 <<< left_shift_i, int'(in2_mult_i), in2_shift_i);
        end
        r = rescale(r, int'(out_mult_i), out_shift_i) + out_offset_i;
        if (r < act_min_i) r = act_min_i;
        if (r > act_max_i) r = act_max_i;
        if (r > 127) r = 127;
        if (r < -128) r = -128;
        return r[7:0];
    endfunction

    function automatic logic [ew_pkg::VEC_W-1:0] vec_model(logic [1:0] op, logic [3:0] grp,
            logic [ew_pkg::VEC_W-1:0] a, logic [ew_pkg::VEC_W-1:0] b);
        logic [ew_pkg::VEC_W-1:0] y;
        y = '0;
        for (int i = 0; i < ew_pkg::LANES; i++) begin
            if (i < grp) y[i*8 +: 8] = lane_model(op, a[i*8 +: 8], b[i*8 +: 8]);
        end
        return y;
    endfunction

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic default_params();
        in1_offset_i = 3;
        in2_offset_i = -2;
        left_shift_i = 4;
        in1_mult_i = 32'h4000_0000;
        in1_shift_i = 1;
        in2_mult_i = 32'h4000_0000;
        in2_shift_i = 1;
        out_mult_i = 32'h4000_0000;
        out_shift_i = -3;
        out_offset_i = 1;
        act_min_i = -128;
        act_max_i = 127;
    endtask

    task automatic add_vec(logic [1:0] op, logic [3:0] grp, logic [63:0] a, logic [63:0] b);
        op_q.push_back(op);
        grp_q.push_back(grp);
        a_q.push_back(a);
        b_q.push_back(b);
        exp_q.push_back(vec_model(op, grp, a, b));
    endtask

    task automatic wait_output(output bit seen);
        int waited;
        seen = 1'b0;
        waited = 0;
        while (!seen && waited < ew_pkg::LANE_LATENCY + 4) begin
            @(negedge clk);
            if (valid_o) seen = 1'b1;
            else waited++;
        end
    endtask

    // drives the queued vectors back to back and checks each result in order
    task automatic run_vectors(string name);
        int n;
        n = a_q.size();
        fork
            begin
                for (int k = 0; k < n; k++) begin
                    @(posedge clk);
                    #2;
                    valid_i = 1'b1;
                    op_i = op_q[k];
                    groups_i = grp_q[k];
                    data_a_i = a_q[k];
                    data_b_i = b_q[k];
                end
                @(posedge clk);
                #2 valid_i = 1'b0;
            end
            begin
                bit seen;
                for (int k = 0; k < n; k++) begin
                    wait_output(seen);
                    if (!seen) begin
                        $display("%s: output vector %0d never arrived", name, k);
                        errors++;
                        break;
                    end
                    assert (data_o == exp_q[k]) else begin
                        $display("[FAIL] %0t: %s vector %0d data_o %h, expected %h",
                                 $time, name, k, data_o, exp_q[k]);
                        errors++;
                    end
                    assert (elem_idx_o == 13'(exp_idx)) else begin
                        $display("[FAIL] %0t: %s vector %0d elem_idx_o %0d, expected %0d",
                                 $time, name, k, elem_idx_o, exp_idx);
                        errors++;
                    end
                    exp_idx++;
                end
            end
        join
        op_q.delete();
        grp_q.delete();
        a_q.delete();
        b_q.delete();
        exp_q.delete();
    endtask

    task automatic end_test(string name, int errs_before);
        if (errors == errs_before) begin
            pass_cnt++;
            $display("%s: passed", name);
        end else begin
            fail_cnt++;
            $display("%s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic test_reset_idle();
        int e0;
        e0 = errors;
        repeat (ew_pkg::LANE_LATENCY + 3) begin
            @(negedge clk);
            assert (!valid_o && data_o == '0 && elem_idx_o == '0) else begin
                $display("[FAIL] %0t: idle outputs valid_o %b data_o %h elem_idx_o %0d",
                         $time, valid_o, data_o, elem_idx_o);
                errors++;
            end
        end
        end_test("reset and idle", e0);
    endtask

    task automatic test_add();
        int e0;
        e0 = errors;
        @(posedge clk);
        #2;
        default_params();
        add_vec(ew_pkg::OP_ADD, 4'd8, 64'h7f80_0110_f0e5_3cc3, 64'h0102_7f80_2233_c4d5);
        add_vec(ew_pkg::OP_ADD, 4'd8, 64'h1122_3344_5566_7788, 64'hfedc_ba98_7654_3210);
        run_vectors("quantized add");
        end_test("quantized add", e0);
    endtask

    task automatic test_sub_mul();
        int e0;
        e0 = errors;
        @(posedge clk);
        #2;
        default_params();
        act_min_i = -1000;
        act_max_i = 1000;
        add_vec(ew_pkg::OP_SUB, 4'd8, 64'h7f80_40c0_10f0_0a05, 64'h807f_c040_10f0_050a);
        add_vec(ew_pkg::OP_MUL, 4'd8, 64'h7f80_40c0_10f0_0a05, 64'h807f_c040_10f0_050a);
        run_vectors("sub and mul, int8 bounds");
        // narrow activation range so the clamp wins over int8 saturation
        @(posedge clk);
        #2;
        act_min_i = -50;
        act_max_i = 40;
        add_vec(ew_pkg::OP_SUB, 4'd8, 64'h7f80_40c0_10f0_0a05, 64'h807f_c040_10f0_050a);
        add_vec(ew_pkg::OP_MUL, 4'd8, 64'h7f80_40c0_10f0_0a05, 64'h807f_c040_10f0_050a);
        run_vectors("sub and mul, activation clamp");
        end_test("quantized sub and mul", e0);
    endtask

    task automatic test_groups();
        int e0;
        e0 = errors;
        @(posedge clk);
        #2;
        default_params();
        add_vec(ew_pkg::OP_ADD, 4'd3, 64'h0102_0304_0506_0708, 64'h1020_3040_5060_7080);
        run_vectors("group masking");
        end_test("group masking", e0);
    endtask

    task automatic test_random_stream();
        int e0;
        e0 = errors;
        @(posedge clk);
        #2;
        default_params();
        repeat (20) begin
            add_vec(2'($urandom_range(0, 3)), 4'($urandom_range(0, 15)),
                    {$urandom, $urandom}, {$urandom, $urandom});
        end
        run_vectors("random stream");
        end_test("back-to-back random stream", e0);
    endtask

    task automatic test_init_clear();
        int e0;
        e0 = errors;
        @(posedge clk);
        #2 init_i = 1'b1;
        @(posedge clk);
        #2 init_i = 1'b0;
        @(negedge clk);
        assert (elem_idx_o == '0) else begin
            $display("[FAIL] %0t: elem_idx_o %0d after init, expected 0", $time, elem_idx_o);
            errors++;
        end
        exp_idx = 0;
        add_vec(ew_pkg::OP_SUB, 4'd8, 64'h0a0b_0c0d_0e0f_1011, 64'h0101_0101_0101_0101);
        add_vec(ew_pkg::OP_ADD, 4'd8, 64'h2020_2020_2020_2020, 64'hf0f0_f0f0_f0f0_f0f0);
        run_vectors("index restart");
        end_test("init clears index", e0);
    endtask

    initial begin
        void'($urandom(81));
        rst = 1'b0;
        init_i = 1'b0;
        valid_i = 1'b0;
        op_i = '0;
        groups_i = '0;
        data_a_i = '0;
        data_b_i = '0;
        default_params();
        repeat (3) @(posedge clk);
        #2 rst = 1'b1;
        test_reset_idle();
        test_add();
        test_sub_mul();
        test_groups();
        test_random_stream();
        test_init_clear();
        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
